/* Bender.yml */
package:
  name: tsc_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/tsc_pkg.sv
      - src/register_file.sv
      - src/control_decode.sv
      - src/forward_unit.sv
      - src/hazard_unit.sv
      - src/execute_alu.sv
      - src/tsc_core.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - testbench/tb_tsc_core.sv

/* src/control_decode.sv */
`timescale 1ns/1ns
`include "tsc_consts.svh"

module control_decode (
    input  tsc_pkg::instr_t instr,
    output tsc_pkg::ctrl_t  ctrl,
    output logic [1:0]      dest,
    output logic            use_rs,
    output logic            use_rt,
    output logic            is_jmp
);

    import tsc_pkg::*;

    always_comb begin
        ctrl   = '0;
        dest   = instr.i_fmt.rt;
        use_rs = 1'b0;
        use_rt = 1'b0;
        is_jmp = 1'b0;
        case (instr.r_fmt.opcode)
            `OP_RTYPE: begin
                dest = instr.r_fmt.rd;
                case (instr.r_fmt.func)
                    `FN_ADD, `FN_SUB, `FN_AND, `FN_ORR: begin
                        ctrl.reg_write = 1'b1;
                        use_rs         = 1'b1;
                        use_rt         = 1'b1;
                        case (instr.r_fmt.func)
                            `FN_SUB: ctrl.alu_op = ALU_SUB;
                            `FN_AND: ctrl.alu_op = ALU_AND;
                            `FN_ORR: ctrl.alu_op = ALU_ORR;
                            default: ctrl.alu_op = ALU_ADD;
                        endcase
                    end
                    `FN_WWD: begin
                        ctrl.alu_op = ALU_PASS_A;
                        ctrl.is_wwd = 1'b1;
                        use_rs      = 1'b1;
                    end
                    `FN_JPR: begin
                        ctrl.is_jpr = 1'b1;
                        use_rs      = 1'b1;
                    end
                    `FN_HLT: ctrl.is_hlt = 1'b1;
                    default: begin
                        // unknown function, falls through as a no-op
                    end
                endcase
            end
            `OP_ADI: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                use_rs           = 1'b1;
            end
            `OP_LHI: begin
                ctrl.alu_op    = ALU_LHI;
                ctrl.reg_write = 1'b1;
            end
            `OP_LWD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.mem_read    = 1'b1;
                use_rs           = 1'b1;
            end
            `OP_SWD: begin
                // rt carries the store data
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
                use_rs           = 1'b1;
                use_rt           = 1'b1;
            end
            `OP_BNE, `OP_BEQ: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_eq = (instr.r_fmt.opcode == `OP_BEQ);
                use_rs         = 1'b1;
                use_rt         = 1'b1;
            end
            `OP_JMP: is_jmp = 1'b1;
            default: begin
                // all-zero control, retires as a no-op
            end
        endcase
    end

endmodule

/* src/execute_alu.sv */
`timescale 1ns/1ns
`include "tsc_consts.svh"

module execute_alu (
    input  tsc_pkg::ctrl_t        ctrl,
    input  logic [`WORD_SIZE-1:0] a,
    input  logic [`WORD_SIZE-1:0] b,
    input  logic [`WORD_SIZE-1:0] imm,
    input  logic [`WORD_SIZE-1:0] pc_next,
    output logic [`WORD_SIZE-1:0] result,
    output logic                  taken,
    output logic [`WORD_SIZE-1:0] target
);

    import tsc_pkg::*;

    logic [`WORD_SIZE-1:0] op_b;
    logic                  equal;

    // loads and stores use the same add for base plus offset
    assign op_b = ctrl.alu_src_imm ? imm : b;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    result = a + op_b;
            ALU_SUB:    result = a - op_b;
            ALU_AND:    result = a & op_b;
            ALU_ORR:    result = a | op_b;
            ALU_PASS_A: result = a;
            ALU_LHI:    result = {imm[7:0], 8'h00};
            default:    result = '0;
        endcase
    end

    // branches compare the registers, never the immediate
    assign equal = (a == b);

    assign taken = ctrl.is_jpr
                || (ctrl.is_branch && (ctrl.branch_eq ? equal : !equal));

    assign target = ctrl.is_jpr ? a : pc_next + imm;

endmodule

/* src/forward_unit.sv */
`timescale 1ns/1ns

module forward_unit (
    input  logic [1:0]        rs,
    input  logic [1:0]        rt,
    input  logic              mem_wr,
    input  logic [1:0]        mem_rd,
    input  logic              wb_wr,
    input  logic [1:0]        wb_rd,
    output tsc_pkg::fwd_sel_t fwd_a,
    output tsc_pkg::fwd_sel_t fwd_b
);

    import tsc_pkg::*;

    // the younger producer in memory wins over writeback
    function automatic fwd_sel_t pick_source(input logic [1:0] src);
        fwd_sel_t sel;
        if (mem_wr && mem_rd == src) begin
            sel = FWD_MEM;
        end else if (wb_wr && wb_rd == src) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_source(rs);
        fwd_b = pick_source(rt);
    end

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit (
    input  logic       use_rs,
    input  logic       use_rt,
    input  logic [1:0] rs,
    input  logic [1:0] rt,
    input  logic       ex_load,
    input  logic [1:0] ex_rd,
    output logic       stall
);

    logic hit_rs;
    logic hit_rt;

    assign hit_rs = use_rs && rs == ex_rd;
    assign hit_rt = use_rt && rt == ex_rd;

    // load data only exists from writeback on, so hold decode one cycle
    assign stall = ex_load && (hit_rs || hit_rt);

endmodule

/* src/register_file.sv */
`timescale 1ns/1ns
`include "tsc_consts.svh"

module register_file (
    input  logic                  Clk,
    input  logic                  rst,
    input  logic [1:0]            rs,
    input  logic [1:0]            rt,
    input  logic                  we,
    input  logic [1:0]            wa,
    input  logic [`WORD_SIZE-1:0] wd,
    output logic [`WORD_SIZE-1:0] rd_a,
    output logic [`WORD_SIZE-1:0] rd_b
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // write-through, decode sees the word retiring this cycle
    assign rd_a = (we && wa == rs) ? wd : regs[rs];
    assign rd_b = (we && wa == rt) ? wd : regs[rt];

    a_write_addr_known: assert property (@(posedge Clk) disable iff (rst)
        we |-> !$isunknown(wa));

endmodule

/* src/tsc_consts.svh */
`ifndef TSC_CONSTS_SVH
`define TSC_CONSTS_SVH

// datapath width and register count
`define WORD_SIZE 16
`define NUM_REGS  4

// opcode field, instr[15:12]
`define OP_BNE   4'd0
`define OP_BEQ   4'd1
`define OP_ADI   4'd4
`define OP_LHI   4'd6
`define OP_LWD   4'd7
`define OP_SWD   4'd8
`define OP_JMP   4'd9
`define OP_RTYPE 4'd15

// function field of R-format, instr[5:0]
`define FN_ADD 6'd0
`define FN_SUB 6'd1
`define FN_AND 6'd2
`define FN_ORR 6'd3
`define FN_JPR 6'd25
`define FN_WWD 6'd28
`define FN_HLT 6'd29

`endif

/* src/tsc_core.sv */
`timescale 1ns/1ns
`include "tsc_consts.svh"

module tsc_core (
    input  logic                  Clk,
    input  logic                  rst,
    output logic                  instr_req,
    output logic [`WORD_SIZE-1:0] instr_addr,
    input  logic [`WORD_SIZE-1:0] instr_data,
    output logic                  data_req,
    output logic                  data_we,
    output logic [`WORD_SIZE-1:0] data_addr,
    output logic [`WORD_SIZE-1:0] data_wdata,
    input  logic [`WORD_SIZE-1:0] data_rdata,
    output logic                  out_valid,
    output logic [`WORD_SIZE-1:0] out_data,
    output logic                  halted,
    output logic [`WORD_SIZE-1:0] num_inst
);

    import tsc_pkg::*;

    logic [`WORD_SIZE-1:0] pc;
    logic                  ifid_valid;
    logic [`WORD_SIZE-1:0] ifid_pc;
    idex_t                 idex;
    exmem_t                exmem;
    memwb_t                memwb;

    instr_t                id_instr;
    ctrl_t                 id_ctrl;
    logic [1:0]            id_dest;
    logic                  id_use_rs;
    logic                  id_use_rt;
    logic                  id_is_jmp;
    logic                  id_jump;
    logic                  id_stall;
    logic [`WORD_SIZE-1:0] id_pc_next;
    logic [`WORD_SIZE-1:0] id_read_a;
    logic [`WORD_SIZE-1:0] id_read_b;

    fwd_sel_t              fwd_a;
    fwd_sel_t              fwd_b;
    logic [`WORD_SIZE-1:0] ex_a;
    logic [`WORD_SIZE-1:0] ex_b;
    logic [`WORD_SIZE-1:0] ex_result;
    logic                  ex_taken;
    logic [`WORD_SIZE-1:0] ex_target;
    logic                  ex_redirect;

    logic                  wb_we;
    logic [`WORD_SIZE-1:0] wb_data;
    logic                  halt_pending;

    function automatic logic [`WORD_SIZE-1:0] fwd_value(
        input fwd_sel_t              sel,
        input logic [`WORD_SIZE-1:0] reg_val
    );
        logic [`WORD_SIZE-1:0] val;
        case (sel)
            FWD_MEM: val = exmem.alu_out;
            FWD_WB:  val = wb_data;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    // the fetched word reaches decode one cycle after its address
    assign id_instr   = instr_data;
    assign id_pc_next = ifid_pc + `WORD_SIZE'd1;
    assign id_jump    = ifid_valid && id_is_jmp;

    // an HLT past decode stops fetch and kills everything behind it
    assign halt_pending = halted
                       || (idex.valid && idex.ctrl.is_hlt)
                       || (exmem.valid && exmem.ctrl.is_hlt)
                       || (memwb.valid && memwb.ctrl.is_hlt);

    assign instr_req = !halted;
    // a stalled decode asks again for its own word
    assign instr_addr = id_stall ? ifid_pc : pc;

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc         <= '0;
            ifid_valid <= 1'b0;
        end else if (halt_pending) begin
            ifid_valid <= 1'b0;
        end else if (ex_redirect) begin
            pc         <= ex_target;
            ifid_valid <= 1'b0;
        end else if (id_jump) begin
            pc         <= {id_pc_next[15:12], id_instr.j_fmt.target12};
            ifid_valid <= 1'b0;
        end else if (!id_stall) begin
            pc         <= pc + `WORD_SIZE'd1;
            ifid_valid <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (!id_stall) begin
            ifid_pc <= pc;
        end
    end

    control_decode u_decode (
        .instr  (id_instr),
        .ctrl   (id_ctrl),
        .dest   (id_dest),
        .use_rs (id_use_rs),
        .use_rt (id_use_rt),
        .is_jmp (id_is_jmp)
    );

    register_file u_regfile (
        .Clk  (Clk),
        .rst  (rst),
        .rs   (id_instr.r_fmt.rs),
        .rt   (id_instr.r_fmt.rt),
        .we   (wb_we),
        .wa   (memwb.rd),
        .wd   (wb_data),
        .rd_a (id_read_a),
        .rd_b (id_read_b)
    );

    hazard_unit u_hazard (
        .use_rs  (ifid_valid && id_use_rs),
        .use_rt  (ifid_valid && id_use_rt),
        .rs      (id_instr.r_fmt.rs),
        .rt      (id_instr.r_fmt.rt),
        .ex_load (idex.valid && idex.ctrl.mem_read),
        .ex_rd   (idex.rd),
        .stall   (id_stall)
    );

    always_ff @(posedge Clk) begin
        if (rst) begin
            idex.valid <= 1'b0;
        end else begin
            idex.valid   <= ifid_valid && !id_stall && !ex_redirect && !halt_pending;
            idex.ctrl    <= id_ctrl;
            idex.pc_next <= id_pc_next;
            idex.rs      <= id_instr.r_fmt.rs;
            idex.rt      <= id_instr.r_fmt.rt;
            idex.rd      <= id_dest;
            idex.read_a  <= id_read_a;
            idex.read_b  <= id_read_b;
            idex.imm     <= {{8{id_instr.i_fmt.imm8[7]}}, id_instr.i_fmt.imm8};
        end
    end

    forward_unit u_forward (
        .rs     (idex.rs),
        .rt     (idex.rt),
        .mem_wr (exmem.valid && exmem.ctrl.reg_write),
        .mem_rd (exmem.rd),
        .wb_wr  (wb_we),
        .wb_rd  (memwb.rd),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

    always_comb begin
        ex_a = fwd_value(fwd_a, idex.read_a);
        ex_b = fwd_value(fwd_b, idex.read_b);
    end

    execute_alu u_alu (
        .ctrl    (idex.ctrl),
        .a       (ex_a),
        .b       (ex_b),
        .imm     (idex.imm),
        .pc_next (idex.pc_next),
        .result  (ex_result),
        .taken   (ex_taken),
        .target  (ex_target)
    );

    assign ex_redirect = idex.valid && ex_taken;

    always_ff @(posedge Clk) begin
        if (rst) begin
            exmem.valid <= 1'b0;
        end else begin
            exmem.valid      <= idex.valid;
            exmem.ctrl       <= idex.ctrl;
            exmem.alu_out    <= ex_result;
            exmem.store_data <= ex_b;
            exmem.rd         <= idex.rd;
        end
    end

    assign data_req   = exmem.valid && (exmem.ctrl.mem_read || exmem.ctrl.mem_write);
    assign data_we    = exmem.valid && exmem.ctrl.mem_write;
    assign data_addr  = exmem.alu_out;
    assign data_wdata = exmem.store_data;

    always_ff @(posedge Clk) begin
        if (rst) begin
            memwb.valid <= 1'b0;
        end else begin
            memwb.valid   <= exmem.valid;
            memwb.ctrl    <= exmem.ctrl;
            memwb.alu_out <= exmem.alu_out;
            memwb.rd      <= exmem.rd;
        end
    end

    assign wb_we   = memwb.valid && memwb.ctrl.reg_write;
    assign wb_data = memwb.ctrl.mem_to_reg ? data_rdata : memwb.alu_out;

    // retirement
    always_ff @(posedge Clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            halted    <= 1'b0;
            num_inst  <= '0;
        end else begin
            out_valid <= memwb.valid && memwb.ctrl.is_wwd;
            if (memwb.valid) begin
                num_inst <= num_inst + `WORD_SIZE'd1;
                if (memwb.ctrl.is_hlt) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (memwb.valid && memwb.ctrl.is_wwd) begin
            out_data <= memwb.alu_out;
        end
    end

    a_no_retire_after_halt: assert property (@(posedge Clk) disable iff (rst)
        halted |-> !memwb.valid);

    // load-use costs exactly one bubble
    a_single_stall: assert property (@(posedge Clk) disable iff (rst)
        id_stall |=> !id_stall);

endmodule

/* src/tsc_pkg.sv */
`include "tsc_consts.svh"

package tsc_pkg;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        logic [5:0] func;
    } r_fmt_t;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm8;
    } i_fmt_t;

    typedef struct packed {
        logic [3:0]  opcode;
        logic [11:0] target12;
    } j_fmt_t;

    // one fetched word, read through whichever format the opcode selects
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORR,
        ALU_PASS_A,
        ALU_LHI
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src_imm;
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    branch_eq;
        logic    is_jpr;
        logic    is_wwd;
        logic    is_hlt;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [`WORD_SIZE-1:0] pc_next;
        logic [1:0]            rs;
        logic [1:0]            rt;
        logic [1:0]            rd;
        logic [`WORD_SIZE-1:0] read_a;
        logic [`WORD_SIZE-1:0] read_b;
        logic [`WORD_SIZE-1:0] imm;
    } idex_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [`WORD_SIZE-1:0] alu_out;
        logic [`WORD_SIZE-1:0] store_data;
        logic [1:0]            rd;
    } exmem_t;

    // load data comes from the data port during writeback
    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [`WORD_SIZE-1:0] alu_out;
        logic [1:0]            rd;
    } memwb_t;

endpackage

/* testbench/core_tests.txt */
# records, values hex: test <name> | prog <word> | data <addr> <word> | out <word>
# store <addr> <word> | count <retired instructions> | end (runs the test twice)

test arith
prog 6012  lhi r0, 0x12
prog 4034  adi r0, r0, 0x34
prog 41ff  adi r1, r0, -1
prog f180  add r2, r0, r1
prog f8c1  sub r3, r2, r0
prog fc1c  wwd r3
prog fb42  and r1, r2, r3
prog f603  orr r0, r1, r2
prog f41c  wwd r1
prog f01c  wwd r0
prog 4a7f  adi r2, r2, 0x7f
prog f81c  wwd r2
prog f01d  hlt
out 1233
out 0023
out 2467
out 24e6
count 000d
end

test load_store
prog 4110  adi r1, r0, 0x10
prog 7600  lwd r2, 0(r1)
prog fac0  add r3, r2, r2
prog fc1c  wwd r3
prog 7401  lwd r0, 1(r1)
prog f303  orr r0, r0, r3
prog 8402  swd r0, 2(r1)
prog 7702  lwd r3, 2(r1)
prog 87ff  swd r3, -1(r1)
prog fc1c  wwd r3
prog f01d  hlt
data 0010 00a5
data 0011 1f00
out 014a
out 1f4a
store 0012 1f4a
store 000f 1f4a
count 000b
end

test branch_jump
prog 4005  adi r0, r0, 5
prog 4505  adi r1, r1, 5
prog 1102  beq r0, r1, +2
prog f01c  wwd r0
prog f41c  wwd r1
prog 0102  bne r0, r1, +2
prog f01c  wwd r0
prog 4501  adi r1, r1, 1
prog 0103  bne r0, r1, +3
prog f01c  wwd r0
prog f41c  wwd r1
prog f41c  wwd r1
prog 1101  beq r0, r1, +1
prog f41c  wwd r1
prog 9011  jmp 0x011
prog f01c  wwd r0
prog f41c  wwd r1
prog 4211  adi r2, r0, 0x11
prog f819  jpr r2
prog f81c  wwd r2
prog f81c  wwd r2
prog f01c  wwd r0
prog f81c  wwd r2
prog f01d  hlt
out 0005
out 0006
out 0016
count 000e
end

test loop
prog 4003  adi r0, r0, 3
prog 4502  adi r1, r1, 2
prog 40ff  adi r0, r0, -1
prog 02fd  bne r0, r2, -3
prog f41c  wwd r1
prog f01d  hlt
out 0006
count 000c
end

/* testbench/tb_tsc_core.sv */
`timescale 1ns/1ns
`include "tsc_consts.svh"

module tb_tsc_core;

    logic                  Clk;
    logic                  rst;
    logic                  instr_req;
    logic [`WORD_SIZE-1:0] instr_addr;
    logic [`WORD_SIZE-1:0] instr_data;
    logic                  data_req;
    logic                  data_we;
    logic [`WORD_SIZE-1:0] data_addr;
    logic [`WORD_SIZE-1:0] data_wdata;
    logic [`WORD_SIZE-1:0] data_rdata;
    logic                  out_valid;
    logic [`WORD_SIZE-1:0] out_data;
    logic                  halted;
    logic [`WORD_SIZE-1:0] num_inst;

    logic [`WORD_SIZE-1:0] imem [256];
    logic [`WORD_SIZE-1:0] dmem [256];
    logic                  fetch_pend;
    logic [7:0]            fetch_addr;
    logic                  load_pend;
    logic [7:0]            load_addr;

    // current test record
    string                 test_name;
    string                 run_name;
    logic [`WORD_SIZE-1:0] prog_q[$];
    logic [`WORD_SIZE-1:0] init_addr_q[$];
    logic [`WORD_SIZE-1:0] init_data_q[$];
    logic [`WORD_SIZE-1:0] exp_out_q[$];
    logic [`WORD_SIZE-1:0] exp_st_addr_q[$];
    logic [`WORD_SIZE-1:0] exp_st_data_q[$];
    logic [`WORD_SIZE-1:0] exp_count;
    int                    tests_run;

    // what the core did during the current run
    logic [`WORD_SIZE-1:0] out_q[$];
    logic [`WORD_SIZE-1:0] st_addr_q[$];
    logic [`WORD_SIZE-1:0] st_data_q[$];

    tsc_core DUT (
        .Clk        (Clk),
        .rst        (rst),
        .instr_req  (instr_req),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .data_req   (data_req),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .halted     (halted),
        .num_inst   (num_inst)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    // both memories take the request at the rising edge and answer at the next falling edge
    always @(posedge Clk) begin
        fetch_pend <= instr_req;
        fetch_addr <= instr_addr[7:0];
        load_pend  <= data_req && !data_we;
        load_addr  <= data_addr[7:0];
        if (!rst && data_req && data_we) begin
            dmem[data_addr[7:0]] <= data_wdata;
            st_addr_q.push_back(data_addr);
            st_data_q.push_back(data_wdata);
        end
    end

    always @(negedge Clk) begin
        if (fetch_pend) begin
            instr_data <= imem[fetch_addr];
        end
        if (load_pend) begin
            data_rdata <= dmem[load_addr];
        end
        if (!rst && out_valid) begin
            out_q.push_back(out_data);
        end
    end

    task automatic report_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input logic [`WORD_SIZE-1:0] expected,
                              input logic [`WORD_SIZE-1:0] actual);
        if (actual !== expected) begin
            $display("Error: test %s, %s: expected %h, actual %h",
                     run_name, what, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_count(input string what, input logic [`WORD_SIZE-1:0] expected,
                               input logic [`WORD_SIZE-1:0] actual);
        if (actual !== expected) begin
            $display("Error: test %s, %s: expected %0d, actual %0d",
                     run_name, what, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: test %s, %s: expected %b, actual %b",
                     run_name, what, expected, actual);
            report_failure();
        end
    endtask

    task automatic load_memories();
        for (int a = 0; a < 256; a++) begin
            // opcode 0xA is unused, so a PC that runs away retires no-ops until timeout
            imem[a] = {8'hA0, a[7:0]};
            dmem[a] = {~a[7:0], a[7:0]};
        end
        for (int i = 0; i < prog_q.size(); i++) begin
            imem[i] = prog_q[i];
        end
        for (int i = 0; i < init_addr_q.size(); i++) begin
            dmem[init_addr_q[i][7:0]] = init_data_q[i];
        end
    endtask

    task automatic compare_outputs();
        if (out_q.size() > exp_out_q.size()) begin
            $display("Test %s wrote %0d outputs, more than the %0d expected",
                     run_name, out_q.size(), exp_out_q.size());
            report_failure();
        end
        for (int i = 0; i < out_q.size(); i++) begin
            check_word($sformatf("output %0d", i), exp_out_q[i], out_q[i]);
        end
        if (out_q.size() < exp_out_q.size()) begin
            $display("Test %s is missing outputs: %0d written, %0d expected",
                     run_name, out_q.size(), exp_out_q.size());
            report_failure();
        end
    endtask

    task automatic compare_stores();
        if (st_addr_q.size() > exp_st_addr_q.size()) begin
            $display("Test %s made %0d stores, more than the %0d expected",
                     run_name, st_addr_q.size(), exp_st_addr_q.size());
            report_failure();
        end
        for (int i = 0; i < st_addr_q.size(); i++) begin
            check_word($sformatf("store %0d address", i), exp_st_addr_q[i], st_addr_q[i]);
            check_word($sformatf("store %0d data", i), exp_st_data_q[i], st_data_q[i]);
        end
        if (st_addr_q.size() < exp_st_addr_q.size()) begin
            $display("Test %s is missing stores: %0d made, %0d expected",
                     run_name, st_addr_q.size(), exp_st_addr_q.size());
            report_failure();
        end
    endtask

    task automatic run_program(input int run);
        int cycles;
        run_name = $sformatf("%s #%0d", test_name, run);
        @(negedge Clk);
        rst <= 1'b1;
        load_memories();
        out_q.delete();
        st_addr_q.delete();
        st_data_q.delete();
        repeat (8) @(negedge Clk);
        check_flag("out_valid in reset", 1'b0, out_valid);
        check_flag("halted in reset", 1'b0, halted);
        check_flag("data_req in reset", 1'b0, data_req);
        check_flag("instr_req in reset", 1'b1, instr_req);
        check_count("num_inst in reset", '0, num_inst);
        rst <= 1'b0;
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(negedge Clk);
            cycles++;
        end
        if (!halted) begin
            $display("Test %s timed out: halted did not rise within 2000 cycles", run_name);
            report_failure();
        end
        // give any stray output or store after HLT time to show up
        repeat (6) @(negedge Clk);
        check_flag("instr_req after halt", 1'b0, instr_req);
        check_flag("halted after halt", 1'b1, halted);
        compare_outputs();
        compare_stores();
        check_count("num_inst at halt", exp_count, num_inst);
    endtask

    task automatic parse_line(input string line);
        string                 tag;
        string                 word;
        logic [`WORD_SIZE-1:0] v1;
        logic [`WORD_SIZE-1:0] v2;
        int                    n;
        tag = "";
        n = $sscanf(line, "%s %h %h", tag, v1, v2);
        case (tag)
            "", "#": begin
                // blank line or comment
            end
            "test": begin
                n = $sscanf(line, "%s %s", tag, word);
                test_name = word;
                prog_q.delete();
                init_addr_q.delete();
                init_data_q.delete();
                exp_out_q.delete();
                exp_st_addr_q.delete();
                exp_st_data_q.delete();
                exp_count = '0;
            end
            "prog": prog_q.push_back(v1);
            "data": begin
                init_addr_q.push_back(v1);
                init_data_q.push_back(v2);
            end
            "out": exp_out_q.push_back(v1);
            "store": begin
                exp_st_addr_q.push_back(v1);
                exp_st_data_q.push_back(v2);
            end
            "count": exp_count = v1;
            "end": begin
                // second run after a fresh reset must repeat the first
                run_program(1);
                run_program(2);
                tests_run++;
            end
            default: begin
                $display("Unknown record '%s' in testbench/core_tests.txt", tag);
                report_failure();
            end
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        rst        = 1'b1;
        instr_data = '0;
        data_rdata = '0;
        tests_run  = 0;
        fd = $fopen("testbench/core_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/core_tests.txt");
            report_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
                parse_line(line);
            end
        end
        $fclose(fd);
        if (tests_run == 0) begin
            $display("No tests found in testbench/core_tests.txt");
            report_failure();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* tsc_core.f */
+incdir+src
src/tsc_pkg.sv
src/register_file.sv
src/control_decode.sv
src/forward_unit.sv
src/hazard_unit.sv
src/execute_alu.sv
src/tsc_core.sv
testbench/tb_tsc_core.sv
